/* Bender.yml */
package:
  name: mq_buffer

sources:
  - rtl/mq_pkg.sv
  - rtl/fifo_fwft_ctrl.sv
  - rtl/payload_ram.sv
  - rtl/queue_dispatch.sv
  - rtl/drain_arbiter.sv
  - rtl/mq_buffer_top.sv
  - target: test
    files:
      - verif/mq_checker.sv
      - verif/mq_tb.sv

/* compile.f */
rtl/mq_pkg.sv
rtl/fifo_fwft_ctrl.sv
rtl/payload_ram.sv
rtl/queue_dispatch.sv
rtl/drain_arbiter.sv
rtl/mq_buffer_top.sv
verif/mq_checker.sv
verif/mq_tb.sv

/* rtl/drain_arbiter.sv */
// round-robin queue drain

`timescale 1ns/10ps

module drain_arbiter (
   input  logic                                              clk,
   input  logic                                              reset,
   input  logic                                              flush,
   input  logic                                              out_en,
   input  logic [mq_pkg::num_queues-1:0]                     lane_valid,
   input  logic [mq_pkg::num_queues-1:0][mq_pkg::data_width-1:0] lane_data,
   output logic [mq_pkg::num_queues-1:0]                     pop,
   output logic                                              out_strobe,
   output mq_pkg::queue_word_t                               out_word
);

   import mq_pkg::*;

   logic [qid_width-1:0] last_served;          // queue popped most recently
   logic [qid_width-1:0] sel;                  // winner of this cycle
   logic                 found;                // some queue is non-empty
   logic                 fire;                 // pop issued this cycle

   // search starts one past last_served and wraps
   always_comb begin
      int unsigned idx;
      sel   = last_served;
      found = 1'b0;
      for (int i = 1; i <= num_queues; i++) begin
         idx = (int'(last_served) + i) % num_queues;
         if (!found && lane_valid[idx]) begin
            found = 1'b1;
            sel   = qid_width'(idx);
         end
      end
   end

   assign fire = out_en & ~flush & found;      // flush blocks all pops

   always_comb begin
      pop = '0;
      pop[sel] = fire;                         // at most one queue
   end

   always_ff @(posedge clk) begin
      if (reset || flush) begin
         last_served <= qid_width'(num_queues - 1); // next search begins at queue 0
         out_strobe  <= 1'b0;
      end else begin
         out_strobe <= fire;
         if (fire) last_served <= sel;
      end
   end

   // output word held between strobes
   always_ff @(posedge clk) begin
      if (fire) begin
         out_word.qid  <= sel;                 // tag with source queue
         out_word.data <= lane_data[sel];
      end
   end

endmodule

/* rtl/fifo_fwft_ctrl.sv */
// first-word-fall-through queue controller

`timescale 1ns/10ps

module fifo_fwft_ctrl #(
   parameter int dw          = mq_pkg::data_width,
   parameter int depth_width = mq_pkg::depth_width
) (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   flush,
   input  logic                   push,
   input  logic [dw-1:0]          din,
   output logic                   ready,
   input  logic                   pop,
   output logic [dw-1:0]          dout,
   output logic                   valid,
   output logic                   payload_re,
   output logic [depth_width-1:0] payload_raddr,
   input  logic [dw-1:0]          payload_rdata,
   output logic                   payload_we,
   output logic [depth_width-1:0] payload_waddr,
   output logic [dw-1:0]          payload_wdata
);

   logic [depth_width:0] w_ptr, w_ptr_nxt;     // extra msb tells full from empty
   logic [depth_width:0] r_ptr, r_ptr_nxt;
   logic                 head_vld;             // head word lives in head_q
   logic [dw-1:0]        head_q;
   logic                 head_load, head_clr;
   logic                 conflict;             // write hits the slot being read
   logic                 byp_sel;
   logic [dw-1:0]        byp_q;                // word written alongside the pop

   assign w_ptr_nxt = w_ptr + 1'b1;
   assign r_ptr_nxt = r_ptr + 1'b1;

   always_ff @(posedge clk) begin
      if (reset || flush) begin                // flush drops everything
         w_ptr <= '0;
         r_ptr <= '0;
      end else begin
         if (push) w_ptr <= w_ptr_nxt;
         if (pop)  r_ptr <= r_ptr_nxt;
      end
   end

   assign ready = (w_ptr[depth_width] == r_ptr[depth_width]) |
                  (w_ptr[depth_width-1:0] != r_ptr[depth_width-1:0]); // not full
   assign valid = (w_ptr != r_ptr);            // not empty

   // first word into an empty queue skips the ram
   assign head_load = ~head_vld & ~valid & push;
   assign head_clr  = head_vld & pop;

   always_ff @(posedge clk) begin
      if (reset || flush) head_vld <= 1'b0;
      else if (head_load) head_vld <= 1'b1;
      else if (head_clr)  head_vld <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (head_load) head_q <= din;            // payload only
   end

   // ram read address runs one slot ahead of r_ptr
   assign payload_we    = push;
   assign payload_waddr = w_ptr[depth_width-1:0];
   assign payload_wdata = din;
   assign payload_re    = pop;
   assign payload_raddr = r_ptr_nxt[depth_width-1:0];

   assign conflict = push & pop & (payload_waddr == payload_raddr);

   always_ff @(posedge clk) begin
      if (reset || flush) byp_sel <= 1'b0;
      else if (pop)       byp_sel <= conflict; // re-decided on every pop
   end

   always_ff @(posedge clk) begin
      if (pop) byp_q <= din;                   // capture in case of conflict
   end

   assign dout = head_vld ? head_q : (byp_sel ? byp_q : payload_rdata);

endmodule

/* rtl/mq_buffer_top.sv */
// four-queue receive buffer

`timescale 1ns/10ps

module mq_buffer_top (
   input  logic                                                  clk,
   input  logic                                                  reset,
   input  logic                                                  flush,
   input  logic                                                  in_push,
   input  mq_pkg::queue_word_t                                   in_word,
   input  logic                                                  out_en,
   output logic                                                  in_accept,
   output logic [mq_pkg::num_queues-1:0][mq_pkg::drop_width-1:0] drop_count,
   output logic                                                  out_strobe,
   output mq_pkg::queue_word_t                                   out_word
);

   import mq_pkg::*;

   logic [num_queues-1:0]                 lane_ready;  // per-queue not full
   logic [num_queues-1:0]                 lane_valid;  // per-queue not empty
   logic [num_queues-1:0]                 push;
   logic [num_queues-1:0]                 pop;
   logic [data_width-1:0]                 push_data;   // shared write data
   logic [num_queues-1:0][data_width-1:0] lane_data;   // head words

   queue_dispatch dispatch_i (
      .clk        (clk),
      .reset      (reset),
      .flush      (flush),
      .in_push    (in_push),
      .in_word    (in_word),
      .lane_ready (lane_ready),
      .in_accept  (in_accept),
      .push       (push),
      .push_data  (push_data),
      .drop_count (drop_count)
   );

   for (genvar g = 0; g < num_queues; g++) begin : g_lane
      logic                   ram_we, ram_re;
      logic [depth_width-1:0] ram_waddr, ram_raddr;
      logic [data_width-1:0]  ram_wdata, ram_rdata;

      fifo_fwft_ctrl #(.dw(data_width), .depth_width(depth_width)) ctrl_i (
         .clk           (clk),
         .reset         (reset),
         .flush         (flush),
         .push          (push[g]),
         .din           (push_data),
         .ready         (lane_ready[g]),
         .pop           (pop[g]),
         .dout          (lane_data[g]),
         .valid         (lane_valid[g]),
         .payload_re    (ram_re),
         .payload_raddr (ram_raddr),
         .payload_rdata (ram_rdata),
         .payload_we    (ram_we),
         .payload_waddr (ram_waddr),
         .payload_wdata (ram_wdata)
      );

      payload_ram #(.dw(data_width), .depth_width(depth_width)) ram_i (
         .clk   (clk),
         .we    (ram_we),
         .waddr (ram_waddr),
         .wdata (ram_wdata),
         .re    (ram_re),
         .raddr (ram_raddr),
         .rdata (ram_rdata)
      );
   end

   drain_arbiter arbiter_i (
      .clk        (clk),
      .reset      (reset),
      .flush      (flush),
      .out_en     (out_en),
      .lane_valid (lane_valid),
      .lane_data  (lane_data),
      .pop        (pop),
      .out_strobe (out_strobe),
      .out_word   (out_word)
   );

endmodule

/* rtl/mq_pkg.sv */
// multi-queue receive buffer definitions

package mq_pkg;

   // queue count and addressing
   localparam int num_queues  = 4;             // receive queues
   localparam int qid_width   = 2;             // queue number bits
   localparam int depth_width = 3;             // 8 words per queue

   // payload
   localparam int data_width  = 16;            // word payload bits

   // per-queue discard counters
   localparam int drop_width  = 8;             // saturates at 255

   // word as seen at the input and at the drain output
   typedef struct packed {
      logic [qid_width-1:0]  qid;              // target queue
      logic [data_width-1:0] data;             // payload
   } queue_word_t;

endpackage

/* rtl/payload_ram.sv */
// queue payload storage

`timescale 1ns/10ps

module payload_ram #(
   parameter int dw          = mq_pkg::data_width,
   parameter int depth_width = mq_pkg::depth_width
) (
   input  logic                   clk,
   input  logic                   we,
   input  logic [depth_width-1:0] waddr,
   input  logic [dw-1:0]          wdata,
   input  logic                   re,
   input  logic [depth_width-1:0] raddr,
   output logic [dw-1:0]          rdata
);

   logic [dw-1:0] mem [2**depth_width];        // one word per slot

   always_ff @(posedge clk) begin
      if (we) mem[waddr] <= wdata;             // synchronous write
   end

   // registered read returns old data on a same-address write
   always_ff @(posedge clk) begin
      if (re) rdata <= mem[raddr];             // holds when re is low
   end

endmodule

/* rtl/queue_dispatch.sv */
// input word dispatcher

`timescale 1ns/10ps

module queue_dispatch (
   input  logic                                                      clk,
   input  logic                                                      reset,
   input  logic                                                      flush,
   input  logic                                                      in_push,
   input  mq_pkg::queue_word_t                                       in_word,
   input  logic [mq_pkg::num_queues-1:0]                             lane_ready,
   output logic                                                      in_accept,
   output logic [mq_pkg::num_queues-1:0]                             push,
   output logic [mq_pkg::data_width-1:0]                             push_data,
   output logic [mq_pkg::num_queues-1:0][mq_pkg::drop_width-1:0]     drop_count
);

   import mq_pkg::*;

   logic dropped;                              // push seen but not taken

   assign in_accept = lane_ready[in_word.qid] & ~flush; // addressed queue has room
   assign dropped   = in_push & ~in_accept;
   assign push_data = in_word.data;            // shared by all queues

   always_comb begin
      push = '0;
      push[in_word.qid] = in_push & in_accept; // one-hot to the addressed queue
   end

   // one discard counter per queue
   always_ff @(posedge clk) begin
      if (reset) begin
         drop_count <= '0;
      end else if (dropped && (drop_count[in_word.qid] != '1)) begin
         drop_count[in_word.qid] <= drop_count[in_word.qid] + 1'b1; // stop at max
      end
   end

endmodule

/* verif/mq_checker.sv */
// receive buffer checker

`timescale 1ns/10ps

module mq_checker (
   input  logic                                                  clk,
   input  logic                                                  reset,
   input  logic                                                  flush,
   input  logic                                                  in_push,
   input  mq_pkg::queue_word_t                                   in_word,
   input  logic                                                  out_en,
   input  logic                                                  in_accept,
   input  logic [mq_pkg::num_queues-1:0][mq_pkg::drop_width-1:0] drop_count,
   input  logic                                                  out_strobe,
   input  mq_pkg::queue_word_t                                   out_word,
   input  logic                                                  end_of_test,
   output int                                                    error_count,
   output int                                                    check_count,
   output int                                                    strobe_count,
   output int                                                    bypass_count
);

   import mq_pkg::*;

   localparam int depth    = 2**depth_width;
   localparam int drop_max = 2**drop_width - 1;

   logic [data_width-1:0] slots [num_queues][depth]; // model storage as a ring per queue
   int                    count [num_queues];
   int                    rd_ptr [num_queues];
   int                    drops [num_queues];         // expected discard counts
   int                    last_served;
   bit [num_queues-1:0]   full_seen;
   bit                    exp_strobe;                 // pop issued last cycle
   queue_word_t           exp_word;
   bit                    prev_out_en, prev_flush, ended;

   task automatic value_error(input string test, input logic [31:0] expected,
                              input logic [31:0] actual);
      error_count++;
      $display("Error %s: expected %0h, actual %0h at %0t", test, expected, actual, $time);
   endtask

   task automatic plain_error(input string what);
      error_count++;
      $display("Failure: %s at %0t", what, $time);
   endtask

   task automatic clear_model();
      for (int q = 0; q < num_queues; q++) begin
         count[q]  = 0;
         rd_ptr[q] = 0;
      end
      last_served = num_queues - 1;                   // search restarts at queue 0
      exp_strobe  = 1'b0;
   endtask

   // outputs of this cycle against the model
   task automatic compare_outputs(output bit accept_exp);
      check_count++;
      if (out_strobe && !prev_out_en) plain_error("strobe after a cycle with out_en low");
      if (out_strobe && prev_flush) plain_error("strobe in the cycle after a flush");
      if (out_strobe !== exp_strobe) begin
         value_error("strobe", exp_strobe, out_strobe);
      end else if (out_strobe) begin
         strobe_count++;
         if (out_word.qid !== exp_word.qid)
            value_error("round_robin", exp_word.qid, out_word.qid);
         if (out_word.data !== exp_word.data)
            value_error("data_order", exp_word.data, out_word.data);
      end
      accept_exp = !flush && (count[in_word.qid] < depth); // room and no flush
      if (in_accept !== accept_exp) value_error("in_accept", accept_exp, in_accept);
      for (int q = 0; q < num_queues; q++) begin
         if (drop_count[q] !== drop_width'(drops[q]))
            value_error("drop_count", drops[q], drop_count[q]);
      end
   endtask

   // pop as of this cycle, then the accepted push
   task automatic step_model(input bit accept_exp);
      int sel;
      int q;
      sel = -1;
      if (out_en && !flush) begin
         for (int i = 1; i <= num_queues; i++) begin
            q = (last_served + i) % num_queues;      // wraps 3 to 0
            if (sel < 0 && count[q] > 0) sel = q;
         end
      end
      exp_strobe = (sel >= 0);
      if (exp_strobe) begin
         exp_word.qid  = qid_width'(sel);
         exp_word.data = slots[sel][rd_ptr[sel]];
         if (in_push && accept_exp && in_word.qid == sel && count[sel] == 1)
            bypass_count++;                           // write slot is the next read slot
         rd_ptr[sel] = (rd_ptr[sel] + 1) % depth;
         count[sel]--;
         last_served = sel;
      end
      if (in_push && accept_exp) begin
         q = in_word.qid;
         slots[q][(rd_ptr[q] + count[q]) % depth] = in_word.data;
         count[q]++;
         if (count[q] == depth) full_seen[q] = 1'b1;
      end
      if (in_push && !accept_exp && drops[in_word.qid] < drop_max)
         drops[in_word.qid]++;                        // flush cycles discard too
      if (flush) clear_model();
   endtask

   // inputs and outputs both settled at the falling edge
   always @(negedge clk) begin
      bit accept_exp;
      if (reset) begin
         clear_model();
         foreach (drops[q]) drops[q] = 0;
      end else begin
         compare_outputs(accept_exp);
         step_model(accept_exp);
      end
      prev_out_en = out_en;
      prev_flush  = flush;
      if (end_of_test && !ended) begin
         ended = 1'b1;
         if (full_seen != '1) plain_error("not every queue reached the full state");
         if (bypass_count == 0) plain_error("no push landed on the slot being popped");
      end
   end

endmodule

/* verif/mq_tb.sv */
// receive buffer testbench

`timescale 1ns/10ps

module mq_tb;

   import mq_pkg::*;

   localparam logic [31:0] lfsr_seed = 32'h98d1eb47;
   localparam logic [31:0] lfsr_taps = 32'h80200003;   // x^32+x^22+x^2+x+1
   localparam int fill_cycles    = 500;
   localparam int mixed_cycles   = 900;
   localparam int burst_cycles   = 500;
   localparam int flush_cycles   = 100;
   localparam int flood_at       = 150;                 // fill step from which pushes hit queue 0
   localparam int flush_at       = 40;                  // step of the flush in the last phase
   localparam int total_cycles   = fill_cycles + mixed_cycles + burst_cycles + flush_cycles;
   localparam int timeout_cycles = total_cycles + total_cycles / 4;

   logic clk, reset, flush, in_push, out_en, in_accept, out_strobe, end_of_test;
   queue_word_t in_word, out_word;
   logic [num_queues-1:0][drop_width-1:0] drop_count;
   logic [31:0] lfsr_state = lfsr_seed;
   int cycle_count;
   int error_count, check_count, strobe_count, bypass_count;

   mq_buffer_top dut_i (
      .clk        (clk),
      .reset      (reset),
      .flush      (flush),
      .in_push    (in_push),
      .in_word    (in_word),
      .out_en     (out_en),
      .in_accept  (in_accept),
      .drop_count (drop_count),
      .out_strobe (out_strobe),
      .out_word   (out_word)
   );

   mq_checker chk_i (
      .clk          (clk),
      .reset        (reset),
      .flush        (flush),
      .in_push      (in_push),
      .in_word      (in_word),
      .out_en       (out_en),
      .in_accept    (in_accept),
      .drop_count   (drop_count),
      .out_strobe   (out_strobe),
      .out_word     (out_word),
      .end_of_test  (end_of_test),
      .error_count  (error_count),
      .check_count  (check_count),
      .strobe_count (strobe_count),
      .bypass_count (bypass_count)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;                           // 40 ns period
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      return state[0] ? ((state >> 1) ^ lfsr_taps) : (state >> 1);
   endfunction

   // one lfsr step per bit taken
   task automatic draw_bits(input int n, output logic [31:0] value);
      value = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         value      = {value[30:0], lfsr_state[0]};
      end
   endtask

   // phase 0 fill, 1 mixed, 2 burst, 3 flush
   task automatic drive_cycle(input int phase, input int step);
      logic [31:0] push_bits, qid_bits, data_bits, en_bits, flush_bits;
      logic        flood;
      draw_bits(2, push_bits);
      draw_bits(qid_width, qid_bits);
      draw_bits(data_width, data_bits);
      draw_bits(1, en_bits);
      draw_bits(6, flush_bits);
      flood        = (phase == 0) && (step >= flood_at); // drives queue 0 drops past 255
      in_push      <= (push_bits[1:0] != 2'b00) | flood; // three pushes in four
      in_word.qid  <= flood ? '0 : qid_bits[qid_width-1:0];
      in_word.data <= data_bits[data_width-1:0];
      case (phase)
         0:       out_en <= 1'b0;                       // nothing drains
         2:       out_en <= 1'b1;
         3:       out_en <= en_bits[0] | (step > flush_at);
         default: out_en <= en_bits[0];
      endcase
      case (phase)
         1:       flush <= (flush_bits[5:0] == 6'd0);   // about one in 64
         3:       flush <= (step == flush_at);
         default: flush <= 1'b0;
      endcase
   endtask

   task automatic run_phase(input int phase, input int n_cycles);
      for (int n = 0; n < n_cycles; n++) begin
         @(posedge clk);
         drive_cycle(phase, n);
      end
   endtask

   task automatic print_counts();
      $display("checks %0d, strobes %0d, same-slot pops %0d, errors %0d",
               check_count, strobe_count, bypass_count, error_count);
   endtask

   always @(posedge clk) cycle_count <= cycle_count + 1;

   initial begin
      wait (cycle_count >= timeout_cycles);
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      print_counts();
      $display("Done: errors found");
      $finish;
   end

   initial begin
      reset       = 1'b1;
      flush       = 1'b0;
      in_push     = 1'b0;
      in_word     = '0;
      out_en      = 1'b0;
      end_of_test = 1'b0;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      run_phase(0, fill_cycles);
      run_phase(1, mixed_cycles);
      run_phase(2, burst_cycles);
      run_phase(3, flush_cycles);
      @(posedge clk);
      in_push     <= 1'b0;
      out_en      <= 1'b0;
      flush       <= 1'b0;
      end_of_test <= 1'b1;                              // checker runs its closing checks
      repeat (2) @(posedge clk);
      print_counts();
      if (error_count == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule
